/* isaPkg.sv */
package isaPkg;

    // branch group, conditioned on z
    localparam logic [5:0] opBra  = 6'd0;
    localparam logic [5:0] opBne  = 6'd1;
    localparam logic [5:0] opBeq  = 6'd2;

    // two-source alu group
    localparam logic [5:0] opAnd  = 6'd12;
    localparam logic [5:0] opOrr  = 6'd13;
    localparam logic [5:0] opXor  = 6'd15;
    localparam logic [5:0] opNand = 6'd16;
    localparam logic [5:0] opAdd  = 6'd21;
    localparam logic [5:0] opAdc  = 6'd22;
    localparam logic [5:0] opSub  = 6'd23;

    // flag-setting variants, honour the S bit
    localparam logic [5:0] opAdds = 6'd25;
    localparam logic [5:0] opSubs = 6'd26;
    localparam logic [5:0] opAnds = 6'd27;
    localparam logic [5:0] opOrrs = 6'd28;
    localparam logic [5:0] opXors = 6'd29;

    // instruction word fields
    localparam int opcodeMsb   = 15;
    localparam int opcodeLsb   = 10;
    localparam int setFlagsBit = 9;
    localparam int dstMsb      = 8;
    localparam int dstLsb      = 6;
    localparam int src1Msb     = 5;
    localparam int src1Lsb     = 3;
    localparam int src2Msb     = 2;
    localparam int src2Lsb     = 0;

    // routing class {dst[8], src1[5], src2[2]}, a 1 bit means register file
    localparam int routeBits = 3;
    localparam int numRoutes = 1 << routeBits;

endpackage

/* ctrlPkg.sv */
package ctrlPkg;

    localparam int phaseWidth = 3;
    localparam int numPhases  = 1 << phaseWidth;

    // alu function select
    localparam logic [4:0] aluPassA = 5'b10000;
    localparam logic [4:0] aluAdd   = 5'b10100;
    localparam logic [4:0] aluAdc   = 5'b10101;
    localparam logic [4:0] aluSub   = 5'b10110;
    localparam logic [4:0] aluAnd   = 5'b10111;
    localparam logic [4:0] aluOrr   = 5'b11000;
    localparam logic [4:0] aluXor   = 5'b11001;
    localparam logic [4:0] aluNand  = 5'b11010;

    // register file functions
    localparam logic [2:0] rfHold    = 3'b000; // no effect while enables idle
    localparam logic [2:0] rfLoad    = 3'b010;
    localparam logic [2:0] rfClear   = 3'b011;
    localparam logic [2:0] rfLoadImm = 3'b111;

    // address register file functions
    localparam logic [2:0] arfInc   = 3'b001;
    localparam logic [2:0] arfLoad  = 3'b010;
    localparam logic [2:0] arfClear = 3'b011;

    // enables are active low
    localparam logic [3:0] rfSelNone  = 4'b1111;
    localparam logic [3:0] rfScrS1    = 4'b0111;
    localparam logic [3:0] rfScrS2    = 4'b1011;
    localparam logic [3:0] rfScrBoth  = 4'b0011;
    localparam logic [2:0] arfSelNone = 3'b111;
    localparam logic [2:0] arfSelPc   = 3'b011;

    // output selects
    localparam logic [2:0] outSelScratch1 = 3'b100;
    localparam logic [2:0] outSelScratch2 = 3'b101;
    localparam logic [1:0] arfOutPc       = 2'b00;

    // datapath multiplexers
    localparam logic [1:0] muxAAlu  = 2'b00;
    localparam logic [1:0] muxAArf  = 2'b01;
    localparam logic [1:0] muxAImm  = 2'b11;
    localparam logic [1:0] muxBAlu  = 2'b00;
    localparam logic [1:0] muxBArf  = 2'b01;
    localparam logic [1:0] idleMux  = 2'b00;
    localparam logic       muxCIdle = 1'b0;

endpackage

/* phaseCounter.sv */
`timescale 1ns/1ps

module phaseCounter import ctrlPkg::*; (
    input  logic                 Clock,
    input  logic                 rstN,
    input  logic                 endOfInstr,
    output logic [numPhases-1:0] phase
);

    logic [phaseWidth-1:0] count;

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            count <= '0;
        end else if (endOfInstr) begin
            count <= '0; // next instruction starts with fetch
        end else begin
            count <= count + 1'b1;
        end
    end

    // one-hot timing T0..T7
    assign phase = numPhases'(1) << count;

endmodule

/* instructionDecoder.sv */
`timescale 1ns/1ps

module instructionDecoder import isaPkg::*, ctrlPkg::*; (
    input  logic [15:0]          irOut,
    input  logic                 z,
    output logic                 isBranchTaken,
    output logic                 isBranchSkipped,
    output logic                 isAluTwoSrc,
    output logic [numRoutes-1:0] route,
    output logic [1:0]           src1Code,
    output logic [1:0]           src2Code,
    output logic [3:0]           dstRfSel,
    output logic [2:0]           dstArfSel,
    output logic [4:0]           aluCode,
    output logic                 setFlags
);

    logic [5:0]           opcode;
    logic [routeBits-1:0] routeClass;
    logic [3:0]           dstSel;
    logic                 isBranch;
    logic                 isFlagOp;

    // arf outc code for sp and ar is swapped against the field
    function automatic logic [1:0] srcToCode(input logic [2:0] field);
        case (field)
            3'd2:    return 2'b11; // sp
            3'd3:    return 2'b10; // ar
            default: return field[1:0];
        endcase
    endfunction

    assign opcode = irOut[opcodeMsb:opcodeLsb];

    always_comb begin
        isBranch      = 1'b1;
        isBranchTaken = 1'b0;
        case (opcode)
            opBra:   isBranchTaken = 1'b1;
            opBne:   isBranchTaken = ~z;
            opBeq:   isBranchTaken = z;
            default: isBranch = 1'b0;
        endcase
    end

    assign isBranchSkipped = isBranch & ~isBranchTaken;

    assign isAluTwoSrc = opcode inside {opAnd, opOrr, opXor, opNand, opAdd, opAdc, opSub,
                                        opAdds, opSubs, opAnds, opOrrs, opXors};
    assign isFlagOp    = opcode inside {opAdds, opSubs, opAnds, opOrrs, opXors};
    assign setFlags    = isFlagOp & irOut[setFlagsBit];

    always_comb begin
        case (opcode)
            opAnd, opAnds: aluCode = aluAnd;
            opOrr, opOrrs: aluCode = aluOrr;
            opXor, opXors: aluCode = aluXor;
            opNand:        aluCode = aluNand;
            opAdd, opAdds: aluCode = aluAdd;
            opAdc:         aluCode = aluAdc;
            opSub, opSubs: aluCode = aluSub;
            default:       aluCode = aluPassA;
        endcase
    end

    assign routeClass = {irOut[dstMsb], irOut[src1Msb], irOut[src2Msb]};
    assign route      = numRoutes'(1) << routeClass;

    assign src1Code = srcToCode(irOut[src1Msb:src1Lsb]);
    assign src2Code = srcToCode(irOut[src2Msb:src2Lsb]);

    // active-low enables, 0/1 both hit pc
    always_comb begin
        case (irOut[dstMsb:dstLsb])
            3'd0, 3'd1: dstSel = 4'b0011;
            3'd2:       dstSel = 4'b0110;
            3'd3:       dstSel = 4'b0101;
            3'd4:       dstSel = 4'b0111;
            3'd5:       dstSel = 4'b1011;
            3'd6:       dstSel = 4'b1101;
            default:    dstSel = 4'b1110;
        endcase
    end

    assign dstRfSel  = dstSel;
    assign dstArfSel = dstSel[2:0];

endmodule

/* datapathControl.sv */
`timescale 1ns/1ps

module datapathControl import isaPkg::*, ctrlPkg::*; (
    input  logic [numPhases-1:0] phase,
    input  logic                 isBranchTaken,
    input  logic                 isAluTwoSrc,
    input  logic [numRoutes-1:0] route,
    input  logic [1:0]           src1Code,
    input  logic [1:0]           src2Code,
    input  logic [3:0]           dstRfSel,
    input  logic [2:0]           dstArfSel,
    input  logic [4:0]           aluCode,
    input  logic                 setFlags,
    output logic [2:0]           rfOutASel,
    output logic [2:0]           rfOutBSel,
    output logic [2:0]           rfFunSel,
    output logic [3:0]           rfRegSel,
    output logic [3:0]           rfScrSel,
    output logic [4:0]           aluFunSel,
    output logic                 aluWf,
    output logic [1:0]           arfOutCSel,
    output logic [2:0]           arfFunSel,
    output logic [2:0]           arfRegSel,
    output logic [1:0]           muxASel,
    output logic [1:0]           muxBSel,
    output logic                 muxCSel
);

    logic       fetch;
    logic       branchExec;
    logic       aluExec;
    logic       dstInArf;
    logic       src1InArf;
    logic       src2InArf;
    logic       writePhase;
    logic       clearPhase;
    logic [3:0] scrMask;

    assign fetch      = phase[0] | phase[1];
    assign branchExec = isBranchTaken & ~fetch;
    assign aluExec    = isAluTwoSrc & ~fetch;

    // class index is {dst, src1, src2}
    assign dstInArf  = |route[3:0];
    assign src1InArf = route[0] | route[1] | route[4] | route[5];
    assign src2InArf = route[0] | route[2] | route[4] | route[6];

    // the one phase where the result reaches its destination
    assign writePhase = ((route[3] | route[7]) & phase[2])
                      | ((route[1] | route[2] | route[5] | route[6]) & phase[3])
                      | ((route[0] | route[4]) & phase[4]);

    // rf function is free during an arf write, else one phase later
    assign clearPhase = dstInArf ? writePhase
                      : (((route[5] | route[6]) & phase[4]) | (route[4] & phase[5]));

    assign scrMask = (src1InArf ? rfScrS1 : rfSelNone) & (src2InArf ? rfScrS2 : rfSelNone);

    assign muxCSel = muxCIdle; // no byte-wise memory writes here

    always_comb begin
        rfOutASel  = outSelScratch1;
        rfOutBSel  = outSelScratch2;
        rfFunSel   = rfHold;
        rfRegSel   = rfSelNone;
        rfScrSel   = rfSelNone;
        aluFunSel  = aluPassA;
        aluWf      = 1'b0;
        arfOutCSel = arfOutPc;
        arfFunSel  = arfLoad;
        arfRegSel  = arfSelNone;
        muxASel    = idleMux;
        muxBSel    = idleMux;

        if (fetch) begin
            arfFunSel = arfInc; // pc steps once per fetched byte
            arfRegSel = arfSelPc;
        end

        if (branchExec) begin
            aluFunSel = aluAdd;
            if (phase[2]) begin
                muxASel  = muxAImm; // offset into s1
                rfFunSel = rfLoadImm;
                rfScrSel = rfScrS1;
            end
            if (phase[3]) begin
                arfOutCSel = arfOutPc; // pc into s2
                muxASel    = muxAArf;
                rfFunSel   = rfLoad;
                rfScrSel   = rfScrS2;
            end
            if (phase[4]) begin
                muxBSel   = muxBAlu; // s1 + s2 back into pc
                arfFunSel = arfLoad;
                arfRegSel = arfSelPc;
                rfFunSel  = rfClear;
                rfScrSel  = rfScrBoth;
            end
        end

        if (aluExec) begin
            aluFunSel = aluCode;
            aluWf     = setFlags;
            rfOutASel = src1InArf ? outSelScratch1 : {1'b0, src1Code};
            rfOutBSel = src2InArf ? outSelScratch2 : {1'b0, src2Code};

            // arf operands go through scratch, src1 first
            if (phase[2] && src1InArf) begin
                arfOutCSel = src1Code;
                muxASel    = muxAArf;
                rfFunSel   = rfLoad;
                rfScrSel   = rfScrS1;
            end else if ((phase[2] || (phase[3] && src1InArf)) && src2InArf) begin
                arfOutCSel = src2Code;
                muxASel    = muxAArf;
                rfFunSel   = rfLoad;
                rfScrSel   = rfScrS2;
            end

            if (writePhase) begin
                if (dstInArf) begin
                    muxBSel   = muxBAlu;
                    arfFunSel = arfLoad;
                    arfRegSel = dstArfSel;
                end else begin
                    muxASel  = muxAAlu;
                    rfFunSel = rfLoad;
                    rfRegSel = dstRfSel;
                end
            end

            if (clearPhase && scrMask != rfSelNone) begin
                rfFunSel = rfClear; // leave scratch zeroed
                rfScrSel = scrMask;
            end
        end
    end

endmodule

/* sequenceControl.sv */
`timescale 1ns/1ps

module sequenceControl import isaPkg::*, ctrlPkg::*; (
    input  logic [numPhases-1:0] phase,
    input  logic                 isBranchTaken,
    input  logic                 isBranchSkipped,
    input  logic                 isAluTwoSrc,
    input  logic [numRoutes-1:0] route,
    output logic                 irLh,
    output logic                 irWrite,
    output logic                 memWr,
    output logic                 memCs,
    output logic [1:0]           arfOutDSel,
    output logic                 endOfInstr
);

    logic fetch;
    logic isNop;
    logic aluLast;

    assign fetch = phase[0] | phase[1];

    assign irWrite    = fetch;
    assign irLh       = phase[1]; // low half in T0, high half in T1
    assign memCs      = ~fetch;   // active low, deselected in execute
    assign memWr      = 1'b0;     // fetch only reads
    assign arfOutDSel = arfOutPc; // memory addressed by pc

    // unknown opcodes fall through as nop
    assign isNop = ~(isBranchTaken | isBranchSkipped | isAluTwoSrc);

    // last phase per routing class
    assign aluLast = ((route[3] | route[7]) & phase[2])
                   | ((route[1] | route[2]) & phase[3])
                   | ((route[0] | route[5] | route[6]) & phase[4])
                   | (route[4] & phase[5]);

    assign endOfInstr = ((isBranchSkipped | isNop) & phase[2])
                      | (isBranchTaken & phase[4])
                      | (isAluTwoSrc & aluLast);

endmodule

/* controlUnit.sv */
`timescale 1ns/1ps

module controlUnit import isaPkg::*, ctrlPkg::*; (
    input  logic                 Clock,
    input  logic                 rstN,
    input  logic [15:0]          irOut,
    input  logic                 z,
    output logic [numPhases-1:0] T,
    output logic [2:0]           rfOutASel,
    output logic [2:0]           rfOutBSel,
    output logic [2:0]           rfFunSel,
    output logic [3:0]           rfRegSel,
    output logic [3:0]           rfScrSel,
    output logic [4:0]           aluFunSel,
    output logic                 aluWf,
    output logic [1:0]           arfOutCSel,
    output logic [1:0]           arfOutDSel,
    output logic [2:0]           arfFunSel,
    output logic [2:0]           arfRegSel,
    output logic                 irLh,
    output logic                 irWrite,
    output logic                 memWr,
    output logic                 memCs,
    output logic [1:0]           muxASel,
    output logic [1:0]           muxBSel,
    output logic                 muxCSel
);

    logic [numPhases-1:0] phase;
    logic                 endOfInstr;
    logic                 isBranchTaken;
    logic                 isBranchSkipped;
    logic                 isAluTwoSrc;
    logic [numRoutes-1:0] route;
    logic [1:0]           src1Code;
    logic [1:0]           src2Code;
    logic [3:0]           dstRfSel;
    logic [2:0]           dstArfSel;
    logic [4:0]           aluCode;
    logic                 setFlags;

    assign T = phase;

    phaseCounter phaseCounter0 (
        .Clock      (Clock),
        .rstN       (rstN),
        .endOfInstr (endOfInstr),
        .phase      (phase)
    );

    // irOut and z are held stable from T2 to the end of the instruction
    instructionDecoder instructionDecoder0 (
        .irOut           (irOut),
        .z               (z),
        .isBranchTaken   (isBranchTaken),
        .isBranchSkipped (isBranchSkipped),
        .isAluTwoSrc     (isAluTwoSrc),
        .route           (route),
        .src1Code        (src1Code),
        .src2Code        (src2Code),
        .dstRfSel        (dstRfSel),
        .dstArfSel       (dstArfSel),
        .aluCode         (aluCode),
        .setFlags        (setFlags)
    );

    datapathControl datapathControl0 (
        .phase         (phase),
        .isBranchTaken (isBranchTaken),
        .isAluTwoSrc   (isAluTwoSrc),
        .route         (route),
        .src1Code      (src1Code),
        .src2Code      (src2Code),
        .dstRfSel      (dstRfSel),
        .dstArfSel     (dstArfSel),
        .aluCode       (aluCode),
        .setFlags      (setFlags),
        .rfOutASel     (rfOutASel),
        .rfOutBSel     (rfOutBSel),
        .rfFunSel      (rfFunSel),
        .rfRegSel      (rfRegSel),
        .rfScrSel      (rfScrSel),
        .aluFunSel     (aluFunSel),
        .aluWf         (aluWf),
        .arfOutCSel    (arfOutCSel),
        .arfFunSel     (arfFunSel),
        .arfRegSel     (arfRegSel),
        .muxASel       (muxASel),
        .muxBSel       (muxBSel),
        .muxCSel       (muxCSel)
    );

    sequenceControl sequenceControl0 (
        .phase           (phase),
        .isBranchTaken   (isBranchTaken),
        .isBranchSkipped (isBranchSkipped),
        .isAluTwoSrc     (isAluTwoSrc),
        .route           (route),
        .irLh            (irLh),
        .irWrite         (irWrite),
        .memWr           (memWr),
        .memCs           (memCs),
        .arfOutDSel      (arfOutDSel),
        .endOfInstr      (endOfInstr)
    );

endmodule

/* controlUnit_checker.sv */
`timescale 1ns/1ps

module controlUnit_checker import ctrlPkg::*; (
    input  logic                 Clock,
    input  logic                 rstN,
    input  logic [numPhases-1:0] T,
    input  logic                 irWrite,
    input  logic                 memCs
);

    int errCount = 0; // read by the testbench

    // one-hot, and either a restart at T0 or one step on
    phaseOneHot: assert property (@(posedge Clock) disable iff (!rstN)
            $onehot(T) && (T[0] || T == ($past(T) << 1)))
        else begin
            $error("T is not one-hot or skipped a phase");
            errCount++;
        end

    // instruction register loads in T0 and T1, for exactly two cycles
    irWriteInFetch: assert property (@(posedge Clock) disable iff (!rstN)
            irWrite |-> (T[0] || T[1]) ##1 (irWrite == $past(T[0])))
        else begin
            $error("irWrite outside T0 and T1 or of wrong length");
            errCount++;
        end

    fetchSelectsMem: assert property (@(posedge Clock) disable iff (!rstN) irWrite |-> !memCs)
        else begin
            $error("memCs not selected while irWrite is high");
            errCount++;
        end

endmodule

bind controlUnit controlUnit_checker timingCheck0 (
    .Clock   (Clock),
    .rstN    (rstN),
    .T       (T),
    .irWrite (irWrite),
    .memCs   (memCs)
);

/* controlUnit_tb.sv */
`timescale 1ns/1ps

module controlUnit_tb import isaPkg::*, ctrlPkg::*; ();

    logic                 Clock = 1'b0;
    logic                 rstN;
    logic [15:0]          irOut;
    logic                 z;
    logic [numPhases-1:0] T;
    logic [2:0]           rfOutASel;
    logic [2:0]           rfOutBSel;
    logic [2:0]           rfFunSel;
    logic [3:0]           rfRegSel;
    logic [3:0]           rfScrSel;
    logic [4:0]           aluFunSel;
    logic                 aluWf;
    logic [1:0]           arfOutCSel;
    logic [1:0]           arfOutDSel;
    logic [2:0]           arfFunSel;
    logic [2:0]           arfRegSel;
    logic                 irLh;
    logic                 irWrite;
    logic                 memWr;
    logic                 memCs;
    logic [1:0]           muxASel;
    logic [1:0]           muxBSel;
    logic                 muxCSel;

    logic [15:0] vecIr[$];
    logic        vecZ[$];
    int          vecLen[$];
    logic [4:0]  vecAlu[$];
    logic [3:0]  vecDst[$];
    logic        vecWf[$];

    controlUnit dut0 (.*);

    always #20 Clock = ~Clock;

    task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        if (actual !== expected) begin
            $display("ERR %0t %s: got %0h, expected %0h", $time, what, actual, expected);
            $display(">>> FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic isBranchOp(input logic [5:0] op);
        return op inside {opBra, opBne, opBeq};
    endfunction

    function automatic logic isAluOp(input logic [5:0] op);
        return op inside {opAnd, opOrr, opXor, opNand, opAdd, opAdc, opSub,
                          opAdds, opSubs, opAnds, opOrrs, opXors};
    endfunction

    task automatic readVectors();
        int          fd;
        int          n;
        int          len;
        string       line;
        logic [15:0] ir;
        logic [31:0] zv;
        logic [31:0] alu;
        logic [31:0] dst;
        logic [31:0] wf;
        fd = $fopen("controlUnit_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open controlUnit_vectors.txt");
            $display(">>> FAIL");
            $fatal(1, "missing vector file");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.substr(0, 1) == "//") continue;
            n = $sscanf(line, "%h %h %d %h %h %h", ir, zv, len, alu, dst, wf);
            if (n <= 0) continue; // blank line
            if (n != 6) begin
                $display("malformed vector line: %s", line);
                $display(">>> FAIL");
                $fatal(1, "bad vector file");
            end
            vecIr.push_back(ir);
            vecZ.push_back(zv[0]);
            vecLen.push_back(len);
            vecAlu.push_back(alu[4:0]);
            vecDst.push_back(dst[3:0]);
            vecWf.push_back(wf[0]);
        end
        $fclose(fd);
        if (vecIr.size() == 0) begin
            $display("vector file holds no instructions");
            $display(">>> FAIL");
            $fatal(1, "empty vector file");
        end
    endtask

    // z only matters for branches
    task automatic applyInstr(input int idx);
        irOut <= vecIr[idx];
        z     <= isBranchOp(vecIr[idx][opcodeMsb:opcodeLsb]) ? vecZ[idx] : 1'($urandom);
    endtask

    // entered at the negedge of T0, returns at the negedge of the next T0
    task automatic runInstr(input int idx);
        int         cycle;
        int         writes;
        int         expWrites;
        logic       aluOp;
        logic       rfDst;
        logic [3:0] dstEn;
        logic [3:0] idleEn;
        logic [3:0] otherEn;
        logic [3:0] otherIdle;
        logic [2:0] srcASel;
        logic [2:0] srcBSel;
        aluOp     = isAluOp(vecIr[idx][opcodeMsb:opcodeLsb]);
        rfDst     = aluOp && vecIr[idx][dstMsb];
        idleEn    = rfDst ? rfSelNone : {1'b0, arfSelNone};
        otherIdle = rfDst ? {1'b0, arfSelNone} : rfSelNone;
        expWrites = (vecDst[idx] == idleEn) ? 0 : 1;
        // rf operands read directly, arf operands through scratch
        srcASel   = (aluOp && vecIr[idx][src1Msb]) ? {1'b0, vecIr[idx][src1Msb-1:src1Lsb]}
                                                   : outSelScratch1;
        srcBSel   = (aluOp && vecIr[idx][src2Msb]) ? {1'b0, vecIr[idx][src2Msb-1:src2Lsb]}
                                                   : outSelScratch2;
        writes    = 0;
        cycle     = 0;
        do begin
            checkEq(T, 32'(1) << cycle, "T");
            checkEq(dut0.timingCheck0.errCount, 0, "checker assertions");
            checkEq(muxCSel, muxCIdle, "muxCSel");
            if (cycle < 2) begin
                checkEq(irWrite, 1'b1, "irWrite");
                checkEq(memCs, 1'b0, "memCs");
                checkEq(memWr, 1'b0, "memWr");
                checkEq(irLh, cycle, "irLh");
                checkEq(arfRegSel, arfSelPc, "arfRegSel in fetch");
                checkEq(arfFunSel, arfInc, "arfFunSel in fetch");
                checkEq(arfOutDSel, arfOutPc, "arfOutDSel in fetch");
                checkEq(rfRegSel, rfSelNone, "rfRegSel in fetch");
                checkEq(rfScrSel, rfSelNone, "rfScrSel in fetch");
                checkEq(muxASel, idleMux, "muxASel in fetch");
                checkEq(muxBSel, idleMux, "muxBSel in fetch");
            end else begin
                checkEq(irWrite, 1'b0, "irWrite");
                checkEq(memCs, 1'b1, "memCs");
                checkEq(memWr, 1'b0, "memWr");
                checkEq(aluFunSel, vecAlu[idx], "aluFunSel");
                checkEq(aluWf, vecWf[idx], "aluWf");
                dstEn   = rfDst ? rfRegSel : {1'b0, arfRegSel};
                otherEn = rfDst ? {1'b0, arfRegSel} : rfRegSel;
                checkEq(otherEn, otherIdle, "unused register enable");
                if (dstEn != idleEn) begin
                    writes++;
                    checkEq(dstEn, vecDst[idx], "destination enable");
                    checkEq(rfOutASel, srcASel, "rfOutASel on write");
                    checkEq(rfOutBSel, srcBSel, "rfOutBSel on write");
                    if (rfDst) begin
                        checkEq(rfFunSel, rfLoad, "rfFunSel on write");
                        checkEq(muxASel, muxAAlu, "muxASel on write");
                    end else begin
                        checkEq(arfFunSel, arfLoad, "arfFunSel on write");
                        checkEq(muxBSel, muxBAlu, "muxBSel on write");
                    end
                    if (!aluOp) checkEq(cycle, 4, "branch pc load phase");
                end
                if (!aluOp && cycle == 3) begin
                    checkEq(arfOutCSel, arfOutPc, "arfOutCSel for pc copy"); // pc into s2
                end
            end
            if (cycle == vecLen[idx] - 1 && idx + 1 < vecIr.size()) begin
                @(posedge Clock);
                applyInstr(idx + 1); // next T0 starts on this edge
            end
            @(negedge Clock);
            cycle++;
            if (cycle > 16) begin
                $display("timeout: T0 did not return within 16 cycles");
                $display(">>> FAIL");
                $fatal(1, "timeout");
            end
        end while (T !== numPhases'(1));
        checkEq(cycle, vecLen[idx], "instruction length");
        checkEq(writes, expWrites, "destination write count");
    endtask

    initial begin
        void'($urandom(21228));
        rstN  <= 1'b0;
        irOut <= '0;
        z     <= 1'b0;
        readVectors();
        repeat (3) @(posedge Clock);
        rstN <= 1'b1;
        applyInstr(0);
        @(negedge Clock);
        checkEq(T, 32'(1), "T after reset");
        for (int i = 0; i < vecIr.size(); i++) begin
            runInstr(i);
        end
        if (dut0.timingCheck0.errCount != 0) begin
            $display("timing assertions failed during the run");
            $display(">>> FAIL");
            $fatal(1, "checker errors");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

/* cpuControl.f */
isaPkg.sv
ctrlPkg.sv
phaseCounter.sv
instructionDecoder.sv
datapathControl.sv
sequenceControl.sv
controlUnit.sv
controlUnit_checker.sv
controlUnit_tb.sv

/* controlUnit_vectors.txt */
// irOut(hex) z length(cycles) aluFunSel(hex) dstEnable(hex) aluWf
// z is used for branches only, other instructions get a random z
0005 0 5 14 3 0
0407 1 3 10 7 0
0410 0 5 14 3 0
0820 0 3 10 7 0
0803 1 5 14 3 0
312E 0 3 17 7 0
34A7 0 3 18 6 0
3CC5 0 4 19 5 0
4031 0 4 1A 3 0
5453 0 5 14 3 0
594A 0 6 15 B 0
5D9C 0 5 16 D 0
67F8 0 5 14 E 1
6924 0 3 16 7 0
6F01 0 6 17 7 1
729E 0 4 18 6 1
76C8 0 5 19 5 1
6DF3 0 5 17 E 0
576D 0 3 14 B 0
A3FF 0 3 10 7 0
0C00 0 3 10 7 0
